//--- dac_spi_top.f
common/dac_pkg.sv
spi/spi_sck_gen.sv
spi/spi_shift.sv
hdl/dac_cmd_seq.sv
hdl/dac_spi_top.sv
test/dac_spi_checker.sv
test/tb_dac_spi.sv

//--- test/tb_dac_spi.sv
`timescale 1ns/1ps

module tb_dac_spi;
	import dac_pkg::*;

	// Clocks allowed per wait
	localparam int wait_limit = 200;

	logic CLK50MHZ;
	logic RST;
	logic dac_start;
	logic [cmd_bits-1:0] dac_cmd;
	logic [addr_bits-1:0] dac_addr;
	logic [value_bits-1:0] dac_value;
	logic dac_busy;
	logic dac_done;
	logic [frame_bits-1:0] dac_readback;
	logic spi_sck;
	logic spi_mosi;
	logic dac_cs;
	logic spi_miso;

	// Checker tallies
	logic [31:0] mismatch_cnt;
	logic [31:0] fail_cnt;
	logic [31:0] accepted_cnt;
	logic [31:0] ignored_cnt;
	logic [31:0] frame_cnt;
	logic [31:0] done_cnt;

	logic [15:0] lfsr;
	int timeout_cnt;
	int tb_fail_cnt;
	int sent_cnt;

	dac_spi_top u_dut (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.dac_start(dac_start),
		.dac_cmd(dac_cmd),
		.dac_addr(dac_addr),
		.dac_value(dac_value),
		.dac_busy(dac_busy),
		.dac_done(dac_done),
		.dac_readback(dac_readback),
		.spi_sck(spi_sck),
		.spi_mosi(spi_mosi),
		.dac_cs(dac_cs),
		.spi_miso(spi_miso)
	);

	dac_spi_checker u_checker (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.dac_start(dac_start),
		.dac_cmd(dac_cmd),
		.dac_addr(dac_addr),
		.dac_value(dac_value),
		.dac_busy(dac_busy),
		.dac_done(dac_done),
		.dac_readback(dac_readback),
		.spi_sck(spi_sck),
		.spi_mosi(spi_mosi),
		.dac_cs(dac_cs),
		.spi_miso(spi_miso),
		.mismatch_cnt(mismatch_cnt),
		.fail_cnt(fail_cnt),
		.accepted_cnt(accepted_cnt),
		.ignored_cnt(ignored_cnt),
		.frame_cnt(frame_cnt),
		.done_cnt(done_cnt)
	);

	// 50 MHz
	initial CLK50MHZ = 1'b0;
	always #10 CLK50MHZ = ~CLK50MHZ;

	////////////////////////////////////////////////////////////////////////////
	// Random fields and run control
	////////////////////////////////////////////////////////////////////////////

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic finish_run;
		int total;
		total = mismatch_cnt + fail_cnt + timeout_cnt + tb_fail_cnt;
		$display("Errors: mismatch=%0d other=%0d timeout=%0d tb=%0d, frames=%0d ignored=%0d",
			mismatch_cnt, fail_cnt, timeout_cnt, tb_fail_cnt, frame_cnt, ignored_cnt);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	// One-clock start strobe driven after the edge
	task automatic pulse_start(
		input logic [3:0] cmd,
		input logic [3:0] addr,
		input logic [11:0] value
	);
		@(posedge CLK50MHZ);
		#2;
		dac_start = 1'b1;
		dac_cmd = cmd;
		dac_addr = addr;
		dac_value = value;
		@(posedge CLK50MHZ);
		#2;
		dac_start = 1'b0;
	endtask

	task automatic wait_done;
		int n;
		n = 0;
		do begin
			@(posedge CLK50MHZ);
			n++;
		end while (dac_done !== 1'b1 && n < wait_limit);
		if (dac_done !== 1'b1) begin
			$display("Timeout: no dac_done within %0d clocks", wait_limit);
			timeout_cnt++;
		end
	endtask

	task automatic wait_busy(input logic level);
		int n;
		n = 0;
		do begin
			@(posedge CLK50MHZ);
			n++;
		end while (dac_busy !== level && n < wait_limit);
		if (dac_busy !== level) begin
			$display("Timeout: dac_busy did not go to %b within %0d clocks",
				level, wait_limit);
			timeout_cnt++;
		end
	endtask

	task automatic run_txn(
		input logic [3:0] cmd,
		input logic [3:0] addr,
		input logic [11:0] value
	);
		pulse_start(cmd, addr, value);
		sent_cnt++;
		wait_done();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] c;
		logic [31:0] a;
		logic [31:0] v;
		RST = 1'b0;
		dac_start = 1'b0;
		dac_cmd = '0;
		dac_addr = '0;
		dac_value = '0;
		lfsr = 16'd22427;
		timeout_cnt = 0;
		tb_fail_cnt = 0;
		sent_cnt = 0;
		repeat (8) @(posedge CLK50MHZ);
		#2;
		RST = 1'b1;
		repeat (5) @(posedge CLK50MHZ);

		// All channels then a plain write
		draw_bits(12, v);
		run_txn(cmd_write_update, addr_all, v[11:0]);
		draw_bits(12, v);
		run_txn(cmd_write, 4'd2, v[11:0]);

		// Random fields with every fourth to all channels
		for (int i = 0; i < 12; i++) begin
			draw_bits(1, c);
			draw_bits(4, a);
			draw_bits(12, v);
			if (i % 4 == 3) begin
				a[3:0] = addr_all;
			end
			run_txn(c[0] ? cmd_write_update : cmd_write, a[3:0], v[11:0]);
		end

		// Second start before the frame loads must be dropped
		draw_bits(12, v);
		pulse_start(cmd_write_update, 4'd1, v[11:0]);
		sent_cnt++;
		wait_busy(1'b1);
		pulse_start(cmd_write, 4'd3, ~v[11:0]);
		wait_done();
		wait_busy(1'b0);

		// Reads back the frame of the busy test
		draw_bits(12, v);
		run_txn(cmd_write, 4'd0, v[11:0]);
		repeat (20) @(posedge CLK50MHZ);

		if (accepted_cnt != sent_cnt || frame_cnt != sent_cnt || done_cnt != sent_cnt) begin
			$display("Count wrong: sent %0d, accepted %0d, frames %0d, done pulses %0d",
				sent_cnt, accepted_cnt, frame_cnt, done_cnt);
			tb_fail_cnt++;
		end
		if (ignored_cnt != 1) begin
			$display("Start while busy was seen %0d times instead of once", ignored_cnt);
			tb_fail_cnt++;
		end
		finish_run();
	end

endmodule

//--- test/dac_spi_checker.sv
`timescale 1ns/1ps

module dac_spi_checker (
	input logic CLK50MHZ,
	input logic RST,
	input logic dac_start,
	input logic [dac_pkg::cmd_bits-1:0] dac_cmd,
	input logic [dac_pkg::addr_bits-1:0] dac_addr,
	input logic [dac_pkg::value_bits-1:0] dac_value,
	input logic dac_busy,
	input logic dac_done,
	input logic [dac_pkg::frame_bits-1:0] dac_readback,
	input logic spi_sck,
	input logic spi_mosi,
	input logic dac_cs,
	output logic spi_miso,
	output logic [31:0] mismatch_cnt,
	output logic [31:0] fail_cnt,
	output logic [31:0] accepted_cnt,
	output logic [31:0] ignored_cnt,
	output logic [31:0] frame_cnt,
	output logic [31:0] done_cnt
);
	import dac_pkg::*;

	// Expected words, one queue for the bus and one for dac_done
	logic [frame_bits-1:0] frame_q[$];
	logic [frame_bits-1:0] done_q[$];
	// Word of the last finished transaction, zero after reset
	logic [frame_bits-1:0] last_word;

	// Slave shift registers and its stored echo
	logic [frame_bits-1:0] slave_rx;
	logic [frame_bits-1:0] slave_tx;
	logic [frame_bits-1:0] slave_prev;

	logic started;
	logic cs_q;
	logic sck_q;
	logic done_q1;
	int sck_rises;

	// Frame layout from the DAC data sheet, pads zero
	function automatic logic [frame_bits-1:0] ref_word(
		input logic [3:0] cmd,
		input logic [3:0] addr,
		input logic [11:0] value
	);
		return {8'h00, cmd, addr, value, 4'h0};
	endfunction

	initial begin
		spi_miso = 1'b0;
		slave_rx = '0;
		slave_tx = '0;
		slave_prev = '0;
		last_word = '0;
		started = 1'b0;
		cs_q = 1'b1;
		sck_q = 1'b0;
		done_q1 = 1'b0;
		sck_rises = 0;
		mismatch_cnt = 0;
		fail_cnt = 0;
		accepted_cnt = 0;
		ignored_cnt = 0;
		frame_cnt = 0;
		done_cnt = 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// DAC slave model
	////////////////////////////////////////////////////////////////////////////

	// Echo MSB out as soon as CS falls
	always @(negedge dac_cs) begin
		slave_tx = slave_prev;
		spi_miso = slave_tx[frame_bits-1];
	end

	always @(posedge spi_sck) begin
		if (dac_cs === 1'b0) begin
			slave_rx = {slave_rx[frame_bits-2:0], spi_mosi};
		end
	end

	// Next echo bit after each falling SCK
	always @(negedge spi_sck) begin
		if (dac_cs === 1'b0) begin
			slave_tx = slave_tx << 1;
			spi_miso = slave_tx[frame_bits-1];
		end
	end

	// Frame kept for echo in the next one
	always @(posedge dac_cs) begin
		slave_prev = slave_rx;
	end

	////////////////////////////////////////////////////////////////////////////
	// Comparisons on clock samples
	////////////////////////////////////////////////////////////////////////////

	always @(posedge CLK50MHZ) begin : compare
		logic [frame_bits-1:0] word;
		if (RST === 1'b1) begin
			// Pins idle until first start
			if (!started && (dac_cs !== 1'b1 || spi_sck !== 1'b0 || dac_busy !== 1'b0)) begin
				$display("Reset state wrong at %0t: cs=%b sck=%b busy=%b",
					$time, dac_cs, spi_sck, dac_busy);
				fail_cnt = fail_cnt + 1;
			end
			// Completion and readback
			if (dac_done === 1'b1) begin
				done_cnt = done_cnt + 1;
				if (done_q1) begin
					$display("dac_done held longer than one clock at %0t", $time);
					fail_cnt = fail_cnt + 1;
				end
				if (dac_cs !== 1'b1 || dac_busy !== 1'b0) begin
					$display("At dac_done (%0t) chip select is low or busy is high", $time);
					fail_cnt = fail_cnt + 1;
				end
				if (done_q.size() == 0) begin
					$display("dac_done at %0t without an accepted start", $time);
					fail_cnt = fail_cnt + 1;
				end else begin
					word = done_q.pop_front();
					if (dac_readback !== last_word) begin
						$display("MISMATCH at %0t: readback %h, expected %h",
							$time, dac_readback, last_word);
						mismatch_cnt = mismatch_cnt + 1;
					end
					last_word = word;
				end
			end
			// Starts, taken only while not busy
			if (dac_start === 1'b1) begin
				started = 1'b1;
				if (dac_busy === 1'b0) begin
					word = ref_word(dac_cmd, dac_addr, dac_value);
					frame_q.push_back(word);
					done_q.push_back(word);
					accepted_cnt = accepted_cnt + 1;
				end else begin
					ignored_cnt = ignored_cnt + 1;
				end
			end
			// Frame shape
			if (dac_cs === 1'b0 && spi_sck === 1'b1 && sck_q === 1'b0) begin
				sck_rises = sck_rises + 1;
			end
			if (dac_cs !== cs_q) begin
				if (spi_sck !== 1'b0) begin
					$display("spi_sck high at a chip select edge at %0t", $time);
					fail_cnt = fail_cnt + 1;
				end
				if (dac_cs === 1'b0) begin
					sck_rises = 0;
				end else begin
					frame_cnt = frame_cnt + 1;
					if (sck_rises != frame_bits) begin
						$display("Frame ending at %0t had %0d SCK rising edges",
							$time, sck_rises);
						fail_cnt = fail_cnt + 1;
					end
					if (frame_q.size() == 0) begin
						$display("Frame at %0t without an accepted start", $time);
						fail_cnt = fail_cnt + 1;
					end else begin
						word = frame_q.pop_front();
						if (slave_rx !== word) begin
							$display("MISMATCH at %0t: frame %h, expected %h",
								$time, slave_rx, word);
							mismatch_cnt = mismatch_cnt + 1;
						end
					end
				end
			end
			cs_q = dac_cs;
			sck_q = spi_sck;
			done_q1 = dac_done;
		end
	end

endmodule

//--- hdl/dac_spi_top.sv
`timescale 1ns/1ps

module dac_spi_top (
	input logic CLK50MHZ,
	input logic RST,
	// User side
	input logic dac_start,
	input logic [dac_pkg::cmd_bits-1:0] dac_cmd,
	input logic [dac_pkg::addr_bits-1:0] dac_addr,
	input logic [dac_pkg::value_bits-1:0] dac_value,
	output logic dac_busy,
	output logic dac_done,
	output logic [dac_pkg::frame_bits-1:0] dac_readback,
	// DAC pins
	output logic spi_sck,
	output logic spi_mosi,
	output logic dac_cs,
	input logic spi_miso
);
	import dac_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Internal links
	////////////////////////////////////////////////////////////////////////////

	// Divider control and strobes
	logic sck_en;
	logic sck_trig;
	logic sck_phase;

	// Sequencer to shifter
	logic spi_trig;
	logic spi_done;
	dac_word_t data_in;
	logic [frame_bits-1:0] data_out;

	// Frame sequencing and CS
	dac_cmd_seq u_seq (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.dac_start(dac_start),
		.dac_cmd(dac_cmd),
		.dac_addr(dac_addr),
		.dac_value(dac_value),
		.dac_busy(dac_busy),
		.dac_done(dac_done),
		.dac_readback(dac_readback),
		.dac_cs(dac_cs),
		.sck_en(sck_en),
		.sck_trig(sck_trig),
		.spi_trig(spi_trig),
		.data_in(data_in),
		.spi_done(spi_done),
		.data_out(data_out)
	);

	// Bit strobe divider
	spi_sck_gen u_sck_gen (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.sck_en(sck_en),
		.sck_trig(sck_trig),
		.sck_phase(sck_phase)
	);

	// Frame shifter
	spi_shift u_shift (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.sck_trig(sck_trig),
		.sck_phase(sck_phase),
		.spi_miso(spi_miso),
		.spi_mosi(spi_mosi),
		.spi_sck(spi_sck),
		.data_in(data_in),
		.data_out(data_out),
		.spi_trig(spi_trig),
		.spi_done(spi_done)
	);

endmodule

//--- hdl/dac_cmd_seq.sv
`timescale 1ns/1ps

module dac_cmd_seq (
	input logic CLK50MHZ,
	input logic RST,
	// User side
	input logic dac_start,
	input logic [dac_pkg::cmd_bits-1:0] dac_cmd,
	input logic [dac_pkg::addr_bits-1:0] dac_addr,
	input logic [dac_pkg::value_bits-1:0] dac_value,
	output logic dac_busy,
	output logic dac_done,
	output logic [dac_pkg::frame_bits-1:0] dac_readback,
	// Chip select pin
	output logic dac_cs,
	// Divider
	output logic sck_en,
	input logic sck_trig,
	// Shifter
	output logic spi_trig,
	output dac_pkg::dac_word_t data_in,
	input logic spi_done,
	input logic [dac_pkg::frame_bits-1:0] data_out
);
	import dac_pkg::*;

	logic [2:0] state;

	// Outgoing frame and latched echo
	dac_word_t tx_word;
	dac_word_t rx_word;

	// Start taken
	logic accept;
	// Echo ready from shifter
	logic rx_take;

	// Finish is the dac_done clock, a new start is welcome there too
	assign accept = dac_start && ((state == seq_idle) || (state == seq_finish));
	assign rx_take = (state == seq_shift) && spi_done;

	assign data_in = tx_word;
	assign dac_readback = rx_word.raw;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			state <= seq_idle;
			dac_cs <= 1'b1;
			sck_en <= 1'b0;
			dac_busy <= 1'b0;
			dac_done <= 1'b0;
			spi_trig <= 1'b0;
		end else begin
			// Strobes last one clock
			dac_done <= 1'b0;
			spi_trig <= 1'b0;

			case (state)
				seq_idle, seq_finish: begin
					state <= seq_idle;
					if (accept) begin
						// Select the DAC, start SCK divider
						dac_cs <= 1'b0;
						sck_en <= 1'b1;
						dac_busy <= 1'b1;
						state <= seq_select;
					end
				end
				seq_select: begin
					// One strobe of CS setup before the frame
					if (sck_trig) begin
						spi_trig <= 1'b1;
						state <= seq_shift;
					end
				end
				seq_shift: begin
					if (spi_done) begin
						state <= seq_release;
					end
				end
				seq_release: begin
					// One strobe of CS hold, then deselect
					if (sck_trig) begin
						dac_cs <= 1'b1;
						sck_en <= 1'b0;
						dac_busy <= 1'b0;
						dac_done <= 1'b1;
						state <= seq_finish;
					end
				end
				default: begin
					state <= seq_idle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame build and readback
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		// Fields held stable for the whole transaction
		if (accept) begin
			tx_word.fields.pad_hi <= '0;
			tx_word.fields.cmd <= dac_cmd;
			tx_word.fields.addr <= dac_addr;
			tx_word.fields.value <= dac_value;
			tx_word.fields.pad_lo <= '0;
		end

		// Echo of previous frame
		if (rx_take) begin
			rx_word.raw <= data_out;
		end
	end

endmodule

//--- spi/spi_shift.sv
`timescale 1ns/1ps

module spi_shift (
	input logic CLK50MHZ,
	input logic RST,
	input logic sck_trig,
	input logic sck_phase,
	input logic spi_miso,
	output logic spi_mosi,
	output logic spi_sck,
	input dac_pkg::dac_word_t data_in,
	output logic [dac_pkg::frame_bits-1:0] data_out,
	input logic spi_trig,
	output logic spi_done
);
	import dac_pkg::*;

	logic [1:0] state;

	// spi_trig seen, frame waits for next bit strobe to load
	logic load_pend;

	// Out and in shift registers
	logic [frame_bits-1:0] out_sr;
	logic [frame_bits-1:0] in_sr;

	// Launched bits, top bit set after the last one
	logic [bit_cnt_bits-1:0] bit_cnt;
	logic sent;

	// Bit on the wire between first launch and closing strobe
	logic in_flight;

	// Strobe qualifiers
	logic do_load;
	logic do_launch;
	logic do_capture;

	assign sent = bit_cnt[bit_cnt_bits-1];
	assign in_flight = (state == sh_sending) && (bit_cnt != '0);

	assign do_load = (state == sh_wait) && sck_trig && load_pend;
	assign do_launch = (state == sh_sending) && sck_trig && !sent;
	// From the second launch on, plus the closing strobe
	assign do_capture = (state == sh_sending) && sck_trig && (bit_cnt != '0);

	assign data_out = in_sr;
	assign spi_done = (state == sh_done);

	////////////////////////////////////////////////////////////////////////////
	// Control FSM, MOSI and SCK
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			state <= sh_wait;
			load_pend <= 1'b0;
			bit_cnt <= '0;
			spi_mosi <= 1'b0;
			spi_sck <= 1'b0;
		end else begin
			// SCK lags phase by one clock so it falls on the launch strobe,
			// MISO is sampled before the slave moves it
			spi_sck <= sck_phase && in_flight;

			case (state)
				sh_wait: begin
					if (spi_trig) begin
						load_pend <= 1'b1;
					end
					if (do_load) begin
						load_pend <= 1'b0;
						bit_cnt <= '0;
						state <= sh_sending;
					end
				end
				sh_sending: begin
					if (sck_trig) begin
						if (sent) begin
							// Closing strobe
							spi_mosi <= 1'b0;
							state <= sh_done;
						end else begin
							spi_mosi <= out_sr[frame_bits-1];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				sh_done: begin
					state <= sh_wait;
				end
				default: begin
					state <= sh_wait;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Shift registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (do_load) begin
			out_sr <= data_in.raw;
		end else if (do_launch) begin
			out_sr <= out_sr << 1;
		end

		// MSB of the echo arrives first
		if (do_capture) begin
			in_sr <= {in_sr[frame_bits-2:0], spi_miso};
		end
	end

endmodule

//--- spi/spi_sck_gen.sv
`timescale 1ns/1ps

module spi_sck_gen (
	input logic CLK50MHZ,
	input logic RST,
	input logic sck_en,
	output logic sck_trig,
	output logic sck_phase
);
	import dac_pkg::*;

	// Position inside one SCK period
	logic [sck_cnt_bits-1:0] cnt;
	// Last count of the period
	logic cnt_wrap;

	assign cnt_wrap = (cnt == sck_cnt_bits'(sck_period - 1));

	////////////////////////////////////////////////////////////////////////////
	// Period counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			cnt <= '0;
		end else if (!sck_en) begin
			// Held at zero between frames
			cnt <= '0;
		end else if (cnt_wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Strobe and phase
	////////////////////////////////////////////////////////////////////////////

	// Bit strobe at count zero
	// first one in the very first enabled clock
	assign sck_trig = sck_en && (cnt == '0);

	// Upper half of the period
	assign sck_phase = sck_en && (cnt >= sck_cnt_bits'(sck_half));

endmodule

//--- common/dac_pkg.sv
package dac_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Frame and SCK timing
	////////////////////////////////////////////////////////////////////////////

	// Bits per SPI frame, 32-bit DAC word format
	localparam int frame_bits = 32;

	// System clocks per SCK half period, 12.5 MHz SCK from 50 MHz
	localparam int sck_half = 2;
	localparam int sck_period = 2 * sck_half;
	localparam int sck_cnt_bits = $clog2(sck_period);

	// Bit counter with one extra top bit as end flag
	localparam int bit_cnt_bits = $clog2(frame_bits) + 1;

	////////////////////////////////////////////////////////////////////////////
	// Command word fields
	////////////////////////////////////////////////////////////////////////////

	localparam int pad_hi_bits = 8;
	localparam int cmd_bits = 4;
	localparam int addr_bits = 4;
	localparam int value_bits = 12;
	localparam int pad_lo_bits = 4;

	// Command codes
	localparam logic [cmd_bits-1:0] cmd_write_update = 4'b0011;
	localparam logic [cmd_bits-1:0] cmd_write = 4'b0000;

	// All four channels at once
	localparam logic [addr_bits-1:0] addr_all = 4'b1111;

	// Whole frame word, or its fields MSB first
	typedef union packed {
		logic [frame_bits-1:0] raw;
		struct packed {
			logic [pad_hi_bits-1:0] pad_hi;
			logic [cmd_bits-1:0] cmd;
			logic [addr_bits-1:0] addr;
			logic [value_bits-1:0] value;
			logic [pad_lo_bits-1:0] pad_lo;
		} fields;
	} dac_word_t;

	////////////////////////////////////////////////////////////////////////////
	// FSM state codes
	////////////////////////////////////////////////////////////////////////////

	// Shifter
	localparam logic [1:0] sh_wait = 2'd0;
	localparam logic [1:0] sh_sending = 2'd1;
	localparam logic [1:0] sh_done = 2'd2;

	// Command sequencer
	localparam logic [2:0] seq_idle = 3'd0;
	localparam logic [2:0] seq_select = 3'd1;
	localparam logic [2:0] seq_shift = 3'd2;
	localparam logic [2:0] seq_release = 3'd3;
	localparam logic [2:0] seq_finish = 3'd4;

endpackage
